/* hdl/rp_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// shared widths, bus region map and register offsets
// fixed-point constants of the proportional path
////////////////////////////////////////////////////////////////////////////

package rp_pkg;

  // sample widths
  localparam int ADC_W = 14;                 // adc sample, two's complement
  localparam int DAC_W = 14;                 // dac sample
  localparam int SUM_W = 15;                 // offset + control, before saturation

  // system bus
  localparam int BUS_AW     = 32;
  localparam int BUS_DW     = 32;
  localparam int REGION_LSB = 20;            // 1 MB regions
  localparam int REGION_W   = 3;             // addr[22:20]
  localparam int N_REGIONS  = 8;

  // region map
  localparam int RGN_HK     = 0;             // housekeeping
  localparam int RGN_OFFSET = 2;             // dc offset
  localparam int RGN_PCTRL  = 3;             // proportional controller
  localparam logic [N_REGIONS-1:0] RGN_USED = (1 << RGN_HK) | (1 << RGN_OFFSET) |
                                              (1 << RGN_PCTRL);

  // housekeeping offsets
  localparam logic [REGION_LSB-1:0] REG_ID  = 'h00;
  localparam logic [REGION_LSB-1:0] REG_LED = 'h04;
  localparam logic [REGION_LSB-1:0] REG_CFG = 'h08;  // bit 0 = digital loopback
  localparam int LED_W        = 8;
  localparam int CFG_LOOP_BIT = 0;
  localparam logic [BUS_DW-1:0] HK_ID = 32'h5250_0001;

  // dc offset offsets
  localparam logic [REGION_LSB-1:0] REG_OFF_A = 'h00;
  localparam logic [REGION_LSB-1:0] REG_OFF_B = 'h04;

  // controller offsets
  localparam logic [REGION_LSB-1:0] REG_SP_A = 'h00;
  localparam logic [REGION_LSB-1:0] REG_KP_A = 'h04;
  localparam logic [REGION_LSB-1:0] REG_SP_B = 'h10;
  localparam logic [REGION_LSB-1:0] REG_KP_B = 'h14;

  // fixed point, gain of 4096 is 1.0
  localparam int KP_W     = 16;
  localparam int KP_SHIFT = 12;
  localparam int ERR_W    = ADC_W + 1;       // setpoint - sample, no overflow
  localparam int PROD_W   = ERR_W + KP_W;    // full product

endpackage

/* hdl/sys_bus_decoder.sv */
////////////////////////////////////////////////////////////////////////////
// system bus decoder, splits the address space into 1 MB regions
// strobe gating, read data and acknowledge muxing, unused region tie-off
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module sys_bus_decoder import rp_pkg::*; (
  input  logic [BUS_AW-1:0]                 sys_addr_i,
  input  logic                              sys_wen_i,
  input  logic                              sys_ren_i,
  input  logic [N_REGIONS-1:0][BUS_DW-1:0]  slave_rdata_i,  // one word per region
  input  logic [N_REGIONS-1:0]              slave_ack_i,
  input  logic [N_REGIONS-1:0]              slave_err_i,
  output logic [N_REGIONS-1:0]              region_wen_o,
  output logic [N_REGIONS-1:0]              region_ren_o,
  output logic [BUS_DW-1:0]                 sys_rdata_o,
  output logic                              sys_ack_o,
  output logic                              sys_err_o
);

  logic [REGION_W-1:0]  rgn;       // addressed region
  logic [N_REGIONS-1:0] rgn_sel;   // one-hot select
  logic [N_REGIONS-1:0] rgn_ack;   // ack after tie-off
  logic [N_REGIONS-1:0] rgn_err;

  assign rgn     = sys_addr_i[REGION_LSB +: REGION_W];
  assign rgn_sel = N_REGIONS'(1) << rgn;

  // strobes only reach the addressed slave
  assign region_wen_o = rgn_sel & {N_REGIONS{sys_wen_i}};
  assign region_ren_o = rgn_sel & {N_REGIONS{sys_ren_i}};

  // unused regions ack in the strobe cycle, never err
  assign rgn_ack = (slave_ack_i & RGN_USED) | ((region_wen_o | region_ren_o) & ~RGN_USED);
  assign rgn_err = slave_err_i & RGN_USED;

  // unused regions read as zero
  assign sys_rdata_o = RGN_USED[rgn] ? slave_rdata_i[rgn] : '0;
  assign sys_ack_o   = |(rgn_sel & rgn_ack);
  assign sys_err_o   = |(rgn_sel & rgn_err);

endmodule

/* hdl/housekeeping_regs.sv */
////////////////////////////////////////////////////////////////////////////
// housekeeping slave: id word, led register, loopback config bit
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module housekeeping_regs import rp_pkg::*; (
  input  logic               clk_adc_125mhz_000deg,
  input  logic               reset_i,
  input  logic [BUS_AW-1:0]  sys_addr_i,
  input  logic [BUS_DW-1:0]  sys_wdata_i,
  input  logic               wen_i,
  input  logic               ren_i,
  output logic [BUS_DW-1:0]  rdata_o,
  output logic               ack_o,
  output logic [LED_W-1:0]   led_o,
  output logic               digital_loop_o
);

  logic [REGION_LSB-1:0] offs;    // offset inside region
  logic [LED_W-1:0]      led_q;
  logic                  loop_q;  // cfg bit 0

  assign offs = sys_addr_i[REGION_LSB-1:0];

  // register writes, unknown offsets dropped
  always_ff @(posedge clk_adc_125mhz_000deg)
  begin
    if (reset_i)
    begin
      led_q  <= '0;
      loop_q <= 1'b0;
    end
    else if (wen_i)
    begin
      if (offs == REG_LED) led_q  <= sys_wdata_i[LED_W-1:0];
      if (offs == REG_CFG) loop_q <= sys_wdata_i[CFG_LOOP_BIT];
    end
  end

  // ack one cycle after strobe
  always_ff @(posedge clk_adc_125mhz_000deg)
  begin
    if (reset_i) ack_o <= 1'b0;
    else         ack_o <= wen_i | ren_i;
  end

  // read data, valid with ack
  always_ff @(posedge clk_adc_125mhz_000deg)
  begin
    if (ren_i)
    begin
      case (offs)
        REG_ID:  rdata_o <= HK_ID;
        REG_LED: rdata_o <= BUS_DW'(led_q);
        REG_CFG: rdata_o <= BUS_DW'(loop_q) << CFG_LOOP_BIT;
        default: rdata_o <= '0;  // unmapped
      endcase
    end
  end

  assign led_o          = led_q;
  assign digital_loop_o = loop_q;

endmodule

/* hdl/adc_frontend.sv */
////////////////////////////////////////////////////////////////////////////
// adc input registers, negative-slope to two's complement
// digital loopback switch
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module adc_frontend import rp_pkg::*; (
  input  logic                     clk_adc_125mhz_000deg,
  input  logic                     reset_i,
  input  logic        [ADC_W-1:0]  adc_dat_a_i,     // raw unsigned, neg slope
  input  logic        [ADC_W-1:0]  adc_dat_b_i,
  input  logic                     digital_loop_i,
  input  logic signed [ADC_W-1:0]  loop_a_i,        // saturated dac value
  input  logic signed [ADC_W-1:0]  loop_b_i,
  output logic signed [ADC_W-1:0]  adc_a_o,
  output logic signed [ADC_W-1:0]  adc_b_o
);

  logic [ADC_W-1:0] adc_dat_a_q;
  logic [ADC_W-1:0] adc_dat_b_q;

  // input registers, ideally packed into the io blocks
  always_ff @(posedge clk_adc_125mhz_000deg)
  begin
    if (reset_i)
    begin
      adc_dat_a_q <= '0;
      adc_dat_b_q <= '0;
    end
    else
    begin
      adc_dat_a_q <= adc_dat_a_i;
      adc_dat_b_q <= adc_dat_b_i;
    end
  end

  // keep msb, invert the rest, loopback overrides the adc
  assign adc_a_o = digital_loop_i ? loop_a_i : {adc_dat_a_q[ADC_W-1], ~adc_dat_a_q[ADC_W-2:0]};
  assign adc_b_o = digital_loop_i ? loop_b_i : {adc_dat_b_q[ADC_W-1], ~adc_dat_b_q[ADC_W-2:0]};

endmodule

/* hdl/prop_ctrl.sv */
////////////////////////////////////////////////////////////////////////////
// proportional controller, setpoint and gain per channel
// two stage pipeline: error, then scaled and saturated product
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module prop_ctrl import rp_pkg::*; (
  input  logic                     clk_adc_125mhz_000deg,
  input  logic                     reset_i,
  input  logic        [BUS_AW-1:0] sys_addr_i,
  input  logic        [BUS_DW-1:0] sys_wdata_i,
  input  logic                     wen_i,
  input  logic                     ren_i,
  output logic        [BUS_DW-1:0] rdata_o,
  output logic                     ack_o,
  input  logic signed [ADC_W-1:0]  adc_a_i,
  input  logic signed [ADC_W-1:0]  adc_b_i,
  output logic signed [ADC_W-1:0]  pctrl_a_o,
  output logic signed [ADC_W-1:0]  pctrl_b_o
);

  logic        [REGION_LSB-1:0] offs;
  logic signed [ADC_W-1:0]      sp_a, sp_b;      // setpoints
  logic signed [KP_W-1:0]       kp_a, kp_b;      // gains, 4096 = 1.0
  logic signed [ERR_W-1:0]      err_a, err_b;    // stage 1

  // arithmetic shift by KP_SHIFT, clip to sample range
  function automatic logic signed [ADC_W-1:0] scale_sat(input logic signed [PROD_W-1:0] p);
    logic signed [PROD_W-1:0] s;
    s = p >>> KP_SHIFT;
    if (s[PROD_W-1:ADC_W-1] != {(PROD_W-ADC_W+1){s[PROD_W-1]}})
      return {s[PROD_W-1], {(ADC_W-1){~s[PROD_W-1]}}};  // +max or -max
    return s[ADC_W-1:0];
  endfunction

  assign offs = sys_addr_i[REGION_LSB-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // bus registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_adc_125mhz_000deg)
  begin
    if (reset_i)
    begin
      sp_a  <= '0;
      sp_b  <= '0;
      kp_a  <= '0;
      kp_b  <= '0;
      ack_o <= 1'b0;
    end
    else
    begin
      ack_o <= wen_i | ren_i;  // one cycle after strobe
      if (wen_i)
      begin
        case (offs)
          REG_SP_A: sp_a <= sys_wdata_i[ADC_W-1:0];
          REG_KP_A: kp_a <= sys_wdata_i[KP_W-1:0];
          REG_SP_B: sp_b <= sys_wdata_i[ADC_W-1:0];
          REG_KP_B: kp_b <= sys_wdata_i[KP_W-1:0];
          default: ;  // ignored
        endcase
      end
    end
  end

  // readback sign extended
  always_ff @(posedge clk_adc_125mhz_000deg)
  begin
    if (ren_i)
    begin
      case (offs)
        REG_SP_A: rdata_o <= BUS_DW'(sp_a);
        REG_KP_A: rdata_o <= BUS_DW'(kp_a);
        REG_SP_B: rdata_o <= BUS_DW'(sp_b);
        REG_KP_B: rdata_o <= BUS_DW'(kp_b);
        default:  rdata_o <= '0;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_adc_125mhz_000deg)
  begin
    if (reset_i)
    begin
      err_a     <= '0;
      err_b     <= '0;
      pctrl_a_o <= '0;
      pctrl_b_o <= '0;
    end
    else
    begin
      err_a     <= ERR_W'(sp_a) - ERR_W'(adc_a_i);              // stage 1
      err_b     <= ERR_W'(sp_b) - ERR_W'(adc_b_i);
      pctrl_a_o <= scale_sat(PROD_W'(err_a) * PROD_W'(kp_a));   // stage 2
      pctrl_b_o <= scale_sat(PROD_W'(err_b) * PROD_W'(kp_b));
    end
  end

endmodule

/* hdl/dc_offset_regs.sv */
////////////////////////////////////////////////////////////////////////////
// dc offset slave, one signed offset per channel
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module dc_offset_regs import rp_pkg::*; (
  input  logic                     clk_adc_125mhz_000deg,
  input  logic                     reset_i,
  input  logic        [BUS_AW-1:0] sys_addr_i,
  input  logic        [BUS_DW-1:0] sys_wdata_i,
  input  logic                     wen_i,
  input  logic                     ren_i,
  output logic        [BUS_DW-1:0] rdata_o,
  output logic                     ack_o,
  output logic signed [ADC_W-1:0]  off_a_o,
  output logic signed [ADC_W-1:0]  off_b_o
);

  logic [REGION_LSB-1:0] offs;

  assign offs = sys_addr_i[REGION_LSB-1:0];

  // low ADC_W bits of write data
  always_ff @(posedge clk_adc_125mhz_000deg)
  begin
    if (reset_i)
    begin
      off_a_o <= '0;
      off_b_o <= '0;
      ack_o   <= 1'b0;
    end
    else
    begin
      ack_o <= wen_i | ren_i;
      if (wen_i && offs == REG_OFF_A) off_a_o <= sys_wdata_i[ADC_W-1:0];
      if (wen_i && offs == REG_OFF_B) off_b_o <= sys_wdata_i[ADC_W-1:0];
    end
  end

  // reads sign extended, zero elsewhere
  always_ff @(posedge clk_adc_125mhz_000deg)
  begin
    if (ren_i)
    begin
      case (offs)
        REG_OFF_A: rdata_o <= BUS_DW'(off_a_o);
        REG_OFF_B: rdata_o <= BUS_DW'(off_b_o);
        default:   rdata_o <= '0;
      endcase
    end
  end

endmodule

/* hdl/dac_backend.sv */
////////////////////////////////////////////////////////////////////////////
// dac path: offset + control sum, saturation,
// two's complement to negative slope, output registers
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module dac_backend import rp_pkg::*; (
  input  logic                     clk_adc_125mhz_000deg,
  input  logic                     reset_i,
  input  logic signed [ADC_W-1:0]  off_a_i,
  input  logic signed [ADC_W-1:0]  off_b_i,
  input  logic signed [ADC_W-1:0]  pctrl_a_i,
  input  logic signed [ADC_W-1:0]  pctrl_b_i,
  output logic signed [DAC_W-1:0]  dac_a_o,      // saturated, for loopback
  output logic signed [DAC_W-1:0]  dac_b_o,
  output logic        [DAC_W-1:0]  dac_dat_a_o,  // registered, neg slope
  output logic        [DAC_W-1:0]  dac_dat_b_o
);

  logic signed [SUM_W-1:0] sum_a, sum_b;

  // clip when the two top bits disagree
  function automatic logic signed [DAC_W-1:0] sat_sum(input logic signed [SUM_W-1:0] s);
    if (s[SUM_W-1] != s[SUM_W-2])
      return {s[SUM_W-1], {(DAC_W-1){~s[SUM_W-1]}}};  // 0x1fff or 0x2000
    return s[DAC_W-1:0];
  endfunction

  assign sum_a = SUM_W'(off_a_i) + SUM_W'(pctrl_a_i);
  assign sum_b = SUM_W'(off_b_i) + SUM_W'(pctrl_b_i);

  assign dac_a_o = sat_sum(sum_a);
  assign dac_b_o = sat_sum(sum_b);

  ////////////////////////////////////////////////////////////////////////////
  // output registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_adc_125mhz_000deg)
  begin
    if (reset_i)
    begin
      dac_dat_a_o <= {1'b0, {(DAC_W-1){1'b1}}};  // code of zero
      dac_dat_b_o <= {1'b0, {(DAC_W-1){1'b1}}};
    end
    else
    begin
      dac_dat_a_o <= {dac_a_o[DAC_W-1], ~dac_a_o[DAC_W-2:0]};  // msb kept, rest inverted
      dac_dat_b_o <= {dac_b_o[DAC_W-1], ~dac_b_o[DAC_W-2:0]};
    end
  end

endmodule

/* hdl/rp_top.sv */
////////////////////////////////////////////////////////////////////////////
// analog core top: bus decoder, housekeeping, adc frontend,
// proportional controller, dc offset and dac backend
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module rp_top import rp_pkg::*; (
  input  logic               clk_adc_125mhz_000deg,
  input  logic               reset_i,
  input  logic [BUS_AW-1:0]  sys_addr_i,
  input  logic [BUS_DW-1:0]  sys_wdata_i,
  input  logic               sys_wen_i,
  input  logic               sys_ren_i,
  output logic [BUS_DW-1:0]  sys_rdata_o,
  output logic               sys_ack_o,
  output logic               sys_err_o,
  input  logic [ADC_W-1:0]   adc_dat_a_i,
  input  logic [ADC_W-1:0]   adc_dat_b_i,
  output logic [DAC_W-1:0]   dac_dat_a_o,
  output logic [DAC_W-1:0]   dac_dat_b_o,
  output logic [LED_W-1:0]   led_o
);

  // bus
  logic [N_REGIONS-1:0] region_wen, region_ren;
  logic [BUS_DW-1:0]    hk_rdata, off_rdata, pctrl_rdata;
  logic                 hk_ack, off_ack, pctrl_ack;

  // datapath
  logic                    digital_loop;
  logic signed [ADC_W-1:0] adc_a, adc_b;        // converted samples
  logic signed [ADC_W-1:0] pctrl_a, pctrl_b;    // control terms
  logic signed [ADC_W-1:0] off_a, off_b;        // dc offsets
  logic signed [DAC_W-1:0] dac_a, dac_b;        // loopback source

  ////////////////////////////////////////////////////////////////////////////
  // bus decoder, regions 7..0, unused slots are masked inside
  ////////////////////////////////////////////////////////////////////////////

  sys_bus_decoder i_dec (
    .sys_addr_i    (sys_addr_i),
    .sys_wen_i     (sys_wen_i),
    .sys_ren_i     (sys_ren_i),
    .slave_rdata_i ({{4{BUS_DW'(0)}}, pctrl_rdata, off_rdata, BUS_DW'(0), hk_rdata}),
    .slave_ack_i   ({4'b0000, pctrl_ack, off_ack, 1'b0, hk_ack}),
    .slave_err_i   ('0),                         // slaves never err
    .region_wen_o  (region_wen),
    .region_ren_o  (region_ren),
    .sys_rdata_o   (sys_rdata_o),
    .sys_ack_o     (sys_ack_o),
    .sys_err_o     (sys_err_o)
  );

  housekeeping_regs i_hk (
    .clk_adc_125mhz_000deg (clk_adc_125mhz_000deg),
    .reset_i        (reset_i),
    .sys_addr_i     (sys_addr_i),
    .sys_wdata_i    (sys_wdata_i),
    .wen_i          (region_wen[RGN_HK]),
    .ren_i          (region_ren[RGN_HK]),
    .rdata_o        (hk_rdata),
    .ack_o          (hk_ack),
    .led_o          (led_o),
    .digital_loop_o (digital_loop)
  );

  ////////////////////////////////////////////////////////////////////////////
  // analog datapath
  ////////////////////////////////////////////////////////////////////////////

  adc_frontend i_adc (
    .clk_adc_125mhz_000deg (clk_adc_125mhz_000deg),
    .reset_i        (reset_i),
    .adc_dat_a_i    (adc_dat_a_i),
    .adc_dat_b_i    (adc_dat_b_i),
    .digital_loop_i (digital_loop),
    .loop_a_i       (dac_a),
    .loop_b_i       (dac_b),
    .adc_a_o        (adc_a),
    .adc_b_o        (adc_b)
  );

  prop_ctrl i_pctrl (
    .clk_adc_125mhz_000deg (clk_adc_125mhz_000deg),
    .reset_i     (reset_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .wen_i       (region_wen[RGN_PCTRL]),
    .ren_i       (region_ren[RGN_PCTRL]),
    .rdata_o     (pctrl_rdata),
    .ack_o       (pctrl_ack),
    .adc_a_i     (adc_a),
    .adc_b_i     (adc_b),
    .pctrl_a_o   (pctrl_a),
    .pctrl_b_o   (pctrl_b)
  );

  dc_offset_regs i_off (
    .clk_adc_125mhz_000deg (clk_adc_125mhz_000deg),
    .reset_i     (reset_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .wen_i       (region_wen[RGN_OFFSET]),
    .ren_i       (region_ren[RGN_OFFSET]),
    .rdata_o     (off_rdata),
    .ack_o       (off_ack),
    .off_a_o     (off_a),
    .off_b_o     (off_b)
  );

  dac_backend i_dac (
    .clk_adc_125mhz_000deg (clk_adc_125mhz_000deg),
    .reset_i     (reset_i),
    .off_a_i     (off_a),
    .off_b_i     (off_b),
    .pctrl_a_i   (pctrl_a),
    .pctrl_b_i   (pctrl_b),
    .dac_a_o     (dac_a),
    .dac_b_o     (dac_b),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o)
  );

endmodule

/* tests/rp_checker.sv */
////////////////////////////////////////////////////////////////////////////
// checker: reference model of the offset and proportional path,
// value compares, per-test result lines and final counts
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module rp_checker import rp_pkg::*; (
  input logic [DAC_W-1:0]  dac_dat_a_i,
  input logic [DAC_W-1:0]  dac_dat_b_i,
  input logic [LED_W-1:0]  led_i
);

  int pass_count = 0;
  int fail_count = 0;
  int test_errs  = 0;   // errors in the running test
  int test_idx   = 0;
  int test_kind  = 0;

  // sign extend the low w bits
  function automatic int sext(input logic [31:0] v, input int w);
    int m;
    int x;
    m = 1 << w;
    x = int'(v) & (m - 1);
    return (x >= m / 2) ? x - m : x;
  endfunction

  function automatic int clip14(input int v);
    if (v > 8191) return 8191;
    if (v < -8192) return -8192;
    return v;
  endfunction

  // two's complement to negative slope code and back
  function automatic int to_code(input int v);
    logic [13:0] t;
    t = v[13:0];
    return int'({t[13], ~t[12:0]});
  endfunction

  function automatic int from_code(input logic [13:0] c);
    return sext({18'b0, c[13], ~c[12:0]}, 14);
  endfunction

  // one pass of the control law on a converted sample
  function automatic int ctrl_step(input int off, input int sp, input int kp, input int x);
    return clip14(off + clip14(((sp - x) * kp) >>> 12));
  endfunction

  function automatic int model_code(input logic [31:0] off, input logic [31:0] sp,
                                    input logic [31:0] kp, input logic [13:0] adc);
    return to_code(ctrl_step(sext(off, 14), sext(sp, 14), sext(kp, 16), from_code(adc)));
  endfunction

  // loopback settles where the law maps the output onto itself
  function automatic int fixed_point(input logic [31:0] off, input logic [31:0] sp,
                                     input logic [31:0] kp);
    int x;
    x = 0;
    repeat (200) x = ctrl_step(sext(off, 14), sext(sp, 14), sext(kp, 16), x);
    return x;
  endfunction

  task automatic report_failure(input string msg);
    $display("failure at %0t: %s", $time, msg);
    test_errs++;
  endtask

  task automatic check_val(input string name, input logic [31:0] expv, input logic [31:0] act);
    if (expv !== act)
    begin
      $display("[ERROR] t=%0t %s expected %h got %h", $time, name, expv, act);
      test_errs++;
    end
  endtask

  // led pins as seen on the dut
  task automatic check_led(input logic [31:0] expv);
    check_val("led_o", expv, led_i);
  endtask

  task automatic start_test(input int idx, input int kind);
    test_idx  = idx;
    test_kind = kind;
    test_errs = 0;
  endtask

  task automatic finish_test();
    if (test_errs == 0) pass_count++;
    else fail_count++;
    $display("test %0d kind %0d: %s (%0d errors)", test_idx, test_kind,
             (test_errs == 0) ? "ok" : "bad", test_errs);
  endtask

  task automatic check_dac(input logic [31:0] off, input logic [31:0] sp,
                           input logic [31:0] kp, input logic [13:0] adc_a,
                           input logic [13:0] adc_b, input logic [31:0] exp_a,
                           input logic [31:0] exp_b);
    check_val("dac_dat_a_o", model_code(off, sp, kp, adc_a), dac_dat_a_i);
    check_val("dac_dat_b_o", model_code(off, sp, kp, adc_b), dac_dat_b_i);
    if (exp_a != 32'hffff) check_val("dac_dat_a_o", exp_a, dac_dat_a_i);  // fixed in file
    if (exp_b != 32'hffff) check_val("dac_dat_b_o", exp_b, dac_dat_b_i);
  endtask

  task automatic check_loop(input logic [31:0] off, input logic [31:0] sp,
                            input logic [31:0] kp);
    int fix;
    int act_a;
    int act_b;
    fix   = fixed_point(off, sp, kp);
    act_a = from_code(dac_dat_a_i);
    act_b = from_code(dac_dat_b_i);
    if (act_a - fix > 1 || fix - act_a > 1)
    begin
      $display("[ERROR] t=%0t dac_dat_a_o expected %0d +-1 got %0d", $time, fix, act_a);
      test_errs++;
    end
    if (act_b - fix > 1 || fix - act_b > 1)
    begin
      $display("[ERROR] t=%0t dac_dat_b_o expected %0d +-1 got %0d", $time, fix, act_b);
      test_errs++;
    end
  endtask

  task automatic report_counts();
    $display("tests passed %0d, failed %0d", pass_count, fail_count);
  endtask

endmodule

/* tests/tb_rp_top.sv */
////////////////////////////////////////////////////////////////////////////
// testbench for rp_top: clock, reset, watchdog, bus master tasks
// stimulus and expected values read from tests/rp_input_vectors.txt
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_rp_top import rp_pkg::*; ();

  localparam int MAX_TESTS = 64;
  localparam int RGN_UNUSED = 5;              // no slave here

  logic              clk_adc_125mhz_000deg = 1'b0;
  logic              reset_i = 1'b1;
  logic [BUS_AW-1:0] sys_addr_i = '0;
  logic [BUS_DW-1:0] sys_wdata_i = '0;
  logic              sys_wen_i = 1'b0;
  logic              sys_ren_i = 1'b0;
  logic [BUS_DW-1:0] sys_rdata_o;
  logic              sys_ack_o;
  logic              sys_err_o;
  logic [ADC_W-1:0]  adc_dat_a_i = '0;
  logic [ADC_W-1:0]  adc_dat_b_i = '0;
  logic [DAC_W-1:0]  dac_dat_a_o;
  logic [DAC_W-1:0]  dac_dat_b_o;
  logic [LED_W-1:0]  led_o;

  // one entry per vector line
  logic [31:0] v_kind[MAX_TESTS], v_led[MAX_TESTS], v_loop[MAX_TESTS], v_off[MAX_TESTS];
  logic [31:0] v_sp[MAX_TESTS], v_kp[MAX_TESTS], v_rnd[MAX_TESTS], v_adc_a[MAX_TESTS];
  logic [31:0] v_adc_b[MAX_TESTS], v_settle[MAX_TESTS], v_exp_a[MAX_TESTS], v_exp_b[MAX_TESTS];
  int n_tests = 0;
  int wd_cycles = 0;                          // 0 until the vectors are loaded

  always #4 clk_adc_125mhz_000deg = ~clk_adc_125mhz_000deg;  // 125 MHz

  rp_top dut_i (.*);

  rp_checker chk_i (
    .dac_dat_a_i           (dac_dat_a_o),
    .dac_dat_b_i           (dac_dat_b_o),
    .led_i                 (led_o)
  );

  // read vector lines, skip comments and blanks
  task automatic load_vectors();
    int fd;
    int cnt;
    string line;
    fd = $fopen("tests/rp_input_vectors.txt", "r");
    if (fd == 0)
    begin
      chk_i.report_failure("cannot open tests/rp_input_vectors.txt");
      return;
    end
    while (!$feof(fd) && n_tests < MAX_TESTS)
    begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line.substr(0, 0) == "#") continue;
      cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                    v_kind[n_tests], v_led[n_tests], v_loop[n_tests], v_off[n_tests],
                    v_sp[n_tests], v_kp[n_tests], v_rnd[n_tests], v_adc_a[n_tests],
                    v_adc_b[n_tests], v_settle[n_tests], v_exp_a[n_tests], v_exp_b[n_tests]);
      if (cnt == 12) n_tests++;
    end
    $fclose(fd);
  endtask

  // one bus transfer, strobe for a single cycle, wait for ack
  task automatic bus_xfer(input bit wr, input int rgn, input logic [31:0] offs,
                          input logic [31:0] wdata, output logic [31:0] rdata);
    bit got;
    logic err;
    int n;
    @(negedge clk_adc_125mhz_000deg);
    sys_addr_i  = (BUS_AW'(rgn) << REGION_LSB) | offs;
    sys_wdata_i = wdata;
    sys_wen_i   = wr;
    sys_ren_i   = !wr;
    got   = 1'b0;
    err   = 1'b0;
    rdata = '0;
    for (n = 0; n < 16 && !got; n++)
    begin
      @(negedge clk_adc_125mhz_000deg);
      got       = sys_ack_o;                  // sampled before the strobe drops
      err       = sys_err_o;
      rdata     = sys_rdata_o;
      sys_wen_i = 1'b0;
      sys_ren_i = 1'b0;
    end
    if (!got)
      chk_i.report_failure($sformatf("no bus acknowledge within 16 cycles, address %h",
                                     sys_addr_i));
    else
      chk_i.check_val("sys_err_o", 0, err);   // err never set by any region
  endtask

  task automatic write_reg(input int rgn, input logic [31:0] offs, input logic [31:0] val);
    logic [31:0] dummy;
    bus_xfer(1'b1, rgn, offs, val, dummy);
  endtask

  task automatic read_check(input string name, input int rgn, input logic [31:0] offs,
                            input logic [31:0] expv);
    logic [31:0] rd;
    bus_xfer(1'b0, rgn, offs, '0, rd);
    chk_i.check_val(name, expv, rd);
  endtask

  // all registers of one vector line, both channels alike
  task automatic write_regs(input int i);
    write_reg(RGN_HK, REG_LED, v_led[i]);
    write_reg(RGN_HK, REG_CFG, v_loop[i]);
    write_reg(RGN_OFFSET, REG_OFF_A, v_off[i]);
    write_reg(RGN_OFFSET, REG_OFF_B, v_off[i]);
    write_reg(RGN_PCTRL, REG_SP_A, v_sp[i]);
    write_reg(RGN_PCTRL, REG_SP_B, v_sp[i]);
    write_reg(RGN_PCTRL, REG_KP_A, v_kp[i]);
    write_reg(RGN_PCTRL, REG_KP_B, v_kp[i]);
  endtask

  task automatic drive_adc(input logic [13:0] a, input logic [13:0] b, input int settle);
    @(negedge clk_adc_125mhz_000deg);
    adc_dat_a_i = a;
    adc_dat_b_i = b;
    repeat (settle) @(negedge clk_adc_125mhz_000deg);
  endtask

  task automatic run_test(input int i);
    logic [13:0] a, b;
    chk_i.start_test(i, v_kind[i]);
    a = v_adc_a[i][13:0];
    b = v_adc_b[i][13:0];
    if (v_rnd[i] != 0)
    begin
      a = 14'($urandom);
      b = 14'($urandom);
    end
    case (v_kind[i])
      0:                                      // state after reset
      begin
        chk_i.check_val("dac_dat_a_o", 32'h1fff, dac_dat_a_o);
        chk_i.check_val("dac_dat_b_o", 32'h1fff, dac_dat_b_o);
        chk_i.check_led(0);
        read_check("sys_rdata_o id", RGN_HK, REG_ID, v_exp_a[i]);
        read_check("sys_rdata_o unused", RGN_UNUSED, 0, 0);
      end
      1:                                      // register readback
      begin
        write_regs(i);
        chk_i.check_led(v_led[i] & 8'hff);
        read_check("sys_rdata_o led", RGN_HK, REG_LED, v_led[i] & 8'hff);
        read_check("sys_rdata_o off_a", RGN_OFFSET, REG_OFF_A, chk_i.sext(v_off[i], 14));
        read_check("sys_rdata_o off_b", RGN_OFFSET, REG_OFF_B, chk_i.sext(v_off[i], 14));
        read_check("sys_rdata_o sp_a", RGN_PCTRL, REG_SP_A, chk_i.sext(v_sp[i], 14));
        read_check("sys_rdata_o sp_b", RGN_PCTRL, REG_SP_B, chk_i.sext(v_sp[i], 14));
        read_check("sys_rdata_o kp_a", RGN_PCTRL, REG_KP_A, chk_i.sext(v_kp[i], 16));
        read_check("sys_rdata_o kp_b", RGN_PCTRL, REG_KP_B, chk_i.sext(v_kp[i], 16));
      end
      4:                                      // loopback, adc must not matter
      begin
        write_regs(i);
        drive_adc(a, b, v_settle[i]);
        chk_i.check_loop(v_off[i], v_sp[i], v_kp[i]);
        drive_adc(~a, ~b, v_settle[i]);       // new codes, same fixed point
        chk_i.check_loop(v_off[i], v_sp[i], v_kp[i]);
      end
      default:                                // offset and proportional path
      begin
        write_regs(i);
        drive_adc(a, b, v_settle[i]);
        chk_i.check_dac(v_off[i], v_sp[i], v_kp[i], a, b, v_exp_a[i], v_exp_b[i]);
      end
    endcase
    chk_i.finish_test();
  endtask

  initial
  begin
    int i;
    int total;
    void'($urandom(32'h639c_34b7));
    load_vectors();
    total = 10;
    for (i = 0; i < n_tests; i++)
      total += 64 + v_settle[i] * ((v_kind[i] == 4) ? 2 : 1);
    wd_cycles = total;
    repeat (10) @(negedge clk_adc_125mhz_000deg);
    reset_i = 1'b0;
    for (i = 0; i < n_tests; i++)
      run_test(i);
    chk_i.report_counts();
    if (chk_i.fail_count == 0 && n_tests > 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

  // watchdog, limit derived from the loaded tests
  initial
  begin
    wait (wd_cycles > 0);
    repeat (wd_cycles) @(posedge clk_adc_125mhz_000deg);
    $display("watchdog expired after %0d cycles, tests did not complete", wd_cycles);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

/* tests/rp_input_vectors.txt */
# kind led loop offset setpoint gain random adc_a adc_b settle exp_a exp_b (all hex)
# kind 0 reset, 1 readback, 2 gain zero, 3 proportional, 4 loopback; exp ffff = model only
0 00 0 0000 0000 0000 0 0000 0000 08 52500001 0
1 a5 0 3abc 2345 1234 0 0000 0000 08 ffff ffff
1 5a 0 0123 0456 8001 0 0000 0000 08 ffff ffff
2 3c 0 0100 0000 0000 0 1234 2fff 08 1eff 1eff
2 3c 0 3f00 0000 0000 1 0000 0000 08 20ff 20ff
2 00 0 1fff 0000 0000 1 0000 0000 08 0000 0000
2 00 0 2000 0000 0000 1 0000 0000 08 3fff 3fff
3 00 0 0000 0400 1000 0 1fff 1fff 08 1bff 1bff
3 00 0 1000 1fff 7fff 0 3fff 3fff 08 0000 0000
3 00 0 0000 2000 7fff 0 0000 0000 08 3fff 3fff
3 00 0 0123 0800 0c00 1 0000 0000 08 ffff ffff
3 00 0 3f00 3800 f000 1 0000 0000 08 ffff ffff
3 00 0 0000 0000 2000 1 0000 0000 08 ffff ffff
3 00 0 0200 3000 0800 1 0000 0000 08 ffff ffff
3 00 0 0000 0000 7fff 1 0000 0000 08 ffff ffff
4 00 1 0000 0600 0800 1 0000 0000 28 ffff ffff
4 00 1 0000 3a00 0800 1 0000 0000 28 ffff ffff
3 00 0 0000 0100 1000 1 0000 0000 08 ffff ffff

/* verilog.f */
hdl/rp_pkg.sv
hdl/sys_bus_decoder.sv
hdl/housekeeping_regs.sv
hdl/adc_frontend.sv
hdl/prop_ctrl.sv
hdl/dc_offset_regs.sv
hdl/dac_backend.sv
hdl/rp_top.sv
tests/rp_checker.sv
tests/tb_rp_top.sv

/* run_sim.sh */
#!/bin/bash
# build and run the testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_rp_top -o sim_rp \
  && ./obj_dir/sim_rp > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "PASSED" sim.log && ! grep -q "\*\*\* FAILED \*\*\*" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
